/* sim.f */
+incdir+design
design/spi_slave_pkg.sv
design/spi_line_if.sv
design/spi_pin_sync.sv
design/spi_slave_ctrl.sv
design/spi_rx_shifter.sv
design/spi_tx_shifter.sv
design/spi_slave_top.sv
tests/tb_spi_slave.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module tb_spi_slave \
    -f sim.f -Mdir "$OBJ_DIR" -o tb_spi_slave
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/tb_spi_slave" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# Verdict comes from the log
if grep -q "sim failed" "$LOG_FILE"; then
    exit 1
fi
exit 0

/* tests/tb_spi_slave.sv */
`default_nettype none

`include "spi_slave_cfg.svh"

module tb_spi_slave;

    // SCLK half-period in system cycles
    localparam int HALF_SCLK   = 6;
    localparam int WAIT_LIMIT  = 100;
    // Cycles with SS_N high before MISO must read 0
    localparam int IDLE_SETTLE = `SPI_SYNC_STAGES + 3;

    logic       spiClk_internal;
    logic       rst_n_i;
    logic       sclk_i;
    logic       mosi_i;
    logic       ss_n_i;
    logic [7:0] tx_data_i;
    logic       miso_o;
    logic       tx_load_o;
    logic       rx_valid_o;
    logic       busy_o;
    logic [7:0] rx_data_o;

    logic [31:0] rng_state = 32'd43;
    // Words seen at rx_valid_o, tx words latched at tx_load_o, master side words
    logic [7:0] rx_q[$];
    logic [7:0] load_q[$];
    logic [7:0] sent_q[$];
    logic [7:0] miso_q[$];
    // Output levels taken at the last falling clock edge
    logic snap_miso;
    logic snap_busy;
    logic snap_valid;
    logic snap_load;
    int   error_count;
    int   idle_errors;
    int   ss_high_cycles;
    int   tests_passed;
    int   tests_failed;
    bit   timed_out;

    spi_slave_top u_spi_slave_top (
        .spiClk_internal (spiClk_internal),
        .rst_n_i         (rst_n_i),
        .sclk_i          (sclk_i),
        .mosi_i          (mosi_i),
        .ss_n_i          (ss_n_i),
        .tx_data_i       (tx_data_i),
        .miso_o          (miso_o),
        .tx_load_o       (tx_load_o),
        .rx_valid_o      (rx_valid_o),
        .busy_o          (busy_o),
        .rx_data_o       (rx_data_o)
    );

    initial begin
        spiClk_internal = 1'b0;
        forever #4 spiClk_internal = ~spiClk_internal;
    end

    // ------------------------------------------------------------------------
    // Idle MISO check
    // ------------------------------------------------------------------------
    always @(posedge spiClk_internal) begin
        if (!ss_n_i) begin
            ss_high_cycles <= 0;
        end else if (ss_high_cycles < 1000) begin
            ss_high_cycles <= ss_high_cycles + 1;
        end
    end

    // Once SS_N has passed the synchronizer the slave is deselected
    idle_miso_a : assert property (@(posedge spiClk_internal) disable iff (!rst_n_i)
        (ss_high_cycles > IDLE_SETTLE) |-> !miso_o)
        else begin
            idle_errors++;
            $display("MISMATCH %0t: miso_o high while SS_N is idle", $time);
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_byte(output logic [7:0] b);
        rng_state = xorshift32(rng_state);
        b = rng_state[15:8];
    endtask

    // One system cycle that ends on the rising edge where inputs may change
    task automatic tick();
        logic [7:0] b;
        bit         loaded;
        @(negedge spiClk_internal);
        snap_miso  = miso_o;
        snap_busy  = busy_o;
        snap_valid = rx_valid_o;
        snap_load  = tx_load_o;
        loaded     = tx_load_o;
        if (rx_valid_o) begin
            rx_q.push_back(rx_data_o);
        end
        if (tx_load_o) begin
            load_q.push_back(tx_data_i);
        end
        @(posedge spiClk_internal);
        // Slave latched the word on this edge so a fresh one is offered
        if (loaded) begin
            next_byte(b);
            tx_data_i <= b;
        end
    endtask

    task automatic compare_byte(input string what, input logic [7:0] got,
                                input logic [7:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("MISMATCH %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        assert (got == exp) else begin
            error_count++;
            $display("MISMATCH %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Waits for busy_o low or for a number of received words within WAIT_LIMIT cycles
    task automatic wait_for(input string what, input bit for_idle, input int rx_count);
        int n;
        n = 0;
        while (!timed_out && (for_idle ? snap_busy : (rx_q.size() < rx_count))) begin
            if (n == WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("TIMEOUT %0t: gave up waiting for %s", $time, what);
            end else begin
                tick();
                n++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // SPI master in mode 0 with MSB first
    // ------------------------------------------------------------------------
    task automatic shift_word(input logic [7:0] mosi_word, input int nbits,
                              output logic [7:0] miso_word);
        miso_word = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            // MOSI changes with SCLK low
            mosi_i <= mosi_word[i];
            repeat (HALF_SCLK) tick();
            // Snapshot from just before the rising edge
            miso_word[i] = snap_miso;
            sclk_i <= 1'b1;
            repeat (HALF_SCLK) tick();
            sclk_i <= 1'b0;
        end
    endtask

    // Random MOSI words with the last one possibly cut short
    task automatic run_frame(input int nwords, input int last_bits);
        logic [7:0] w;
        logic [7:0] got;
        sent_q.delete();
        miso_q.delete();
        rx_q.delete();
        load_q.delete();
        ss_n_i <= 1'b0;
        repeat (HALF_SCLK) tick();
        for (int k = 0; k < nwords; k++) begin
            next_byte(w);
            sent_q.push_back(w);
            shift_word(w, (k == nwords - 1) ? last_bits : 8, got);
            miso_q.push_back(got);
        end
        if (last_bits == 8) begin
            wait_for("rx_valid_o of the last word", 1'b0, nwords);
        end
        repeat (HALF_SCLK) tick();
        ss_n_i <= 1'b1;
        wait_for("busy_o to fall after SS_N rise", 1'b1, 0);
        // Idle gap between frames
        repeat (4 * HALF_SCLK) tick();
    endtask

    // Full words come back in order and MISO carries each latched tx word
    task automatic check_frame(input int nwords, input int nloads);
        compare_count("rx_valid_o pulses", rx_q.size(), nwords);
        compare_count("tx_load_o pulses", load_q.size(), nloads);
        for (int k = 0; k < nwords && k < rx_q.size() && k < load_q.size(); k++) begin
            compare_byte("received word", rx_q[k], sent_q[k]);
            compare_byte("word sampled on MISO", miso_q[k], load_q[k]);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (!timed_out && error_count + idle_errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int         errs;
        logic [7:0] tx_first;
        rst_n_i   <= 1'b0;
        sclk_i    <= 1'b0;
        mosi_i    <= 1'b0;
        ss_n_i    <= 1'b1;
        tx_data_i <= 8'h00;
        repeat (3) @(posedge spiClk_internal);
        rst_n_i <= 1'b1;

        errs = error_count + idle_errors;
        repeat (2) tick();
        compare_byte("{miso, rx_valid, tx_load, busy} after reset",
                     {4'b0, snap_miso, snap_valid, snap_load, snap_busy}, 8'h00);
        finish_test("reset", errs);

        errs = error_count + idle_errors;
        next_byte(tx_first);
        tx_data_i <= tx_first;
        tick();
        run_frame(1, 8);
        // Extra load comes from the reload while SS_N is still low
        check_frame(1, 2);
        compare_byte("first word sampled on MISO", miso_q[0], tx_first);
        finish_test("single word", errs);

        errs = error_count + idle_errors;
        run_frame(4, 8);
        check_frame(4, 5);
        finish_test("four word frame", errs);

        errs = error_count + idle_errors;
        run_frame(1, 5);
        check_frame(0, 1);
        run_frame(1, 8);
        check_frame(1, 2);
        finish_test("abort after 5 bits", errs);

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out && error_count + idle_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/spi_slave_top.sv */
`default_nettype none

module spi_slave_top (
    input  logic       spiClk_internal,
    input  logic       rst_n_i,
    input  logic       sclk_i,
    input  logic       mosi_i,
    input  logic       ss_n_i,
    input  logic [7:0] tx_data_i,
    output logic       miso_o,
    output logic       tx_load_o,
    output logic       rx_valid_o,
    output logic       busy_o,
    output logic [7:0] rx_data_o
);

    // Controller strobes to the shifters
    logic load_word;
    logic shift_out;
    logic sample_in;
    logic word_done;

    // Raw bit from the transmit shifter
    logic tx_miso;

    // Synchronized pin events
    spi_line_if u_line ();

    // ------------------------------------------------------------------------
    // Pin synchronizer and controller
    // ------------------------------------------------------------------------
    spi_pin_sync u_pin_sync (
        .spiClk_internal (spiClk_internal),
        .rst_n_i         (rst_n_i),
        .sclk_i          (sclk_i),
        .mosi_i          (mosi_i),
        .ss_n_i          (ss_n_i),
        .line_o          (u_line.sync_mp)
    );

    spi_slave_ctrl u_ctrl (
        .spiClk_internal (spiClk_internal),
        .rst_n_i         (rst_n_i),
        .line_i          (u_line.ctrl_mp),
        .load_word_o     (load_word),
        .shift_out_o     (shift_out),
        .sample_in_o     (sample_in),
        .word_done_o     (word_done),
        .busy_o          (busy_o)
    );

    // ------------------------------------------------------------------------
    // Data shifters
    // ------------------------------------------------------------------------
    spi_rx_shifter u_rx (
        .spiClk_internal (spiClk_internal),
        .rst_n_i         (rst_n_i),
        .line_i          (u_line.rx_mp),
        .sample_in_i     (sample_in),
        .word_done_i     (word_done),
        .rx_data_o       (rx_data_o),
        .rx_valid_o      (rx_valid_o)
    );

    spi_tx_shifter u_tx (
        .spiClk_internal (spiClk_internal),
        .rst_n_i         (rst_n_i),
        .load_word_i     (load_word),
        .shift_out_i     (shift_out),
        .tx_data_i       (tx_data_i),
        .miso_o          (tx_miso)
    );

    // MISO only carries data inside a frame, the reload after the last word stays hidden
    assign miso_o    = tx_miso & busy_o;
    assign tx_load_o = load_word;

endmodule

`default_nettype wire

/* design/spi_tx_shifter.sv */
`default_nettype none

`include "spi_slave_cfg.svh"

module spi_tx_shifter (
    input  logic spiClk_internal,
    input  logic rst_n_i,
    input  logic load_word_i,
    input  logic shift_out_i,
    input  spi_slave_pkg::spi_word_t tx_data_i,
    output logic miso_o
);

    // Outgoing word, MSB is the bit on MISO
    spi_slave_pkg::spi_word_t shift_q;

    // ------------------------------------------------------------------------
    // Load and shift
    // ------------------------------------------------------------------------
    always_ff @(posedge spiClk_internal) begin
        if (!rst_n_i) begin
            shift_q <= '0;
        end else if (load_word_i) begin
            // New word wins over a shift in the same cycle
            shift_q <= tx_data_i;
        end else if (shift_out_i) begin
            // Zero fill, so a finished word leaves only zeros behind
            shift_q <= {shift_q[`SPI_WORD_BITS-2:0], 1'b0};
        end
    end

    // Next bit for the master, updated one cycle after each strobe
    assign miso_o = shift_q[`SPI_WORD_BITS-1];

endmodule

`default_nettype wire

/* design/spi_rx_shifter.sv */
`default_nettype none

`include "spi_slave_cfg.svh"

module spi_rx_shifter (
    input  logic spiClk_internal,
    input  logic rst_n_i,
    spi_line_if.rx_mp line_i,
    input  logic sample_in_i,
    input  logic word_done_i,
    output spi_slave_pkg::spi_word_t rx_data_o,
    output logic rx_valid_o
);

    // Bits arrive MSB first and enter at the LSB
    spi_slave_pkg::spi_word_t shift_q;

    // ------------------------------------------------------------------------
    // Shift register and held output word
    // ------------------------------------------------------------------------
    always_ff @(posedge spiClk_internal) begin
        if (sample_in_i) begin
            shift_q <= {shift_q[`SPI_WORD_BITS-2:0], line_i.mosi_bit};
        end
        // Holds until the next finished word
        if (word_done_i) begin
            rx_data_o <= shift_q;
        end
    end

    // Valid pulse one cycle after word_done
    always_ff @(posedge spiClk_internal) begin
        if (!rst_n_i) begin
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= word_done_i;
        end
    end

endmodule

`default_nettype wire

/* design/spi_slave_ctrl.sv */
`default_nettype none

`include "spi_slave_cfg.svh"

module spi_slave_ctrl (
    input  logic spiClk_internal,
    input  logic rst_n_i,
    spi_line_if.ctrl_mp line_i,
    output logic load_word_o,
    output logic shift_out_o,
    output logic sample_in_o,
    output logic word_done_o,
    output logic busy_o
);

    localparam int CNT_BITS = $clog2(`SPI_WORD_BITS);
    localparam logic [CNT_BITS-1:0] BIT_LAST = CNT_BITS'(`SPI_WORD_BITS - 1);

    spi_slave_pkg::slave_state_t state_q;
    spi_slave_pkg::slave_state_t state_d;

    // Rises seen in the current word, wraps to 0 on the last bit
    logic [CNT_BITS-1:0] bit_cnt_q;
    logic [CNT_BITS-1:0] bit_cnt_d;

    // Set for the cycle after ST_DONE when the frame goes on
    logic reload_q;

    // Frame start load or reload for the next word
    logic start_load;

    // ------------------------------------------------------------------------
    // Next state and strobes
    // ------------------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        bit_cnt_d   = bit_cnt_q;
        start_load  = 1'b0;
        sample_in_o = 1'b0;
        shift_out_o = 1'b0;
        word_done_o = 1'b0;

        case (state_q)
            spi_slave_pkg::ST_IDLE: begin
                if (line_i.frame_start) begin
                    // First word goes onto MISO before the first rise
                    start_load = 1'b1;
                    bit_cnt_d  = '0;
                    state_d    = spi_slave_pkg::ST_SHIFT;
                end
            end

            spi_slave_pkg::ST_SHIFT: begin
                if (line_i.sclk_rise && line_i.selected) begin
                    sample_in_o = 1'b1;
                    bit_cnt_d   = bit_cnt_q + 1'b1;
                    if (bit_cnt_q == BIT_LAST) begin
                        state_d = spi_slave_pkg::ST_DONE;
                    end
                end
                // Count of 0 means the fall after the last rise, MISO already reloaded
                if (line_i.sclk_fall && line_i.selected && bit_cnt_q != '0) begin
                    shift_out_o = 1'b1;
                end
            end

            spi_slave_pkg::ST_DONE: begin
                word_done_o = 1'b1;
                if (line_i.selected) begin
                    state_d = spi_slave_pkg::ST_SHIFT;
                end else begin
                    state_d = spi_slave_pkg::ST_IDLE;
                end
            end

            default: begin
                state_d = spi_slave_pkg::ST_IDLE;
            end
        endcase

        // SS_N rising ends the frame and drops any partial word
        if (line_i.frame_end) begin
            state_d = spi_slave_pkg::ST_IDLE;
        end
    end

    assign load_word_o = start_load | (reload_q & line_i.selected);
    assign busy_o      = (state_q != spi_slave_pkg::ST_IDLE);

    always_ff @(posedge spiClk_internal) begin
        if (!rst_n_i) begin
            state_q   <= spi_slave_pkg::ST_IDLE;
            bit_cnt_q <= '0;
            reload_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            bit_cnt_q <= bit_cnt_d;
            reload_q  <= (state_q == spi_slave_pkg::ST_DONE) && line_i.selected;
        end
    end

endmodule

`default_nettype wire

/* design/spi_pin_sync.sv */
`default_nettype none

`include "spi_slave_cfg.svh"

module spi_pin_sync (
    input  logic spiClk_internal,
    input  logic rst_n_i,
    input  logic sclk_i,
    input  logic mosi_i,
    input  logic ss_n_i,
    spi_line_if.sync_mp line_o
);

    localparam int STAGES = `SPI_SYNC_STAGES;

    // Pin bundle order is {ss_n, mosi, sclk}
    // Idle levels: SS_N high, SCLK low
    localparam logic [2:0] PIN_IDLE = 3'b100;

    // All three pins share one synchronizer chain
    logic [2:0] sync_q [STAGES];

    // Synchronized levels at the end of the chain
    logic sclk_s;
    logic mosi_s;
    logic ss_n_s;

    // Previous synchronized levels for edge detection
    logic sclk_d;
    logic ss_n_d;

    assign sclk_s = sync_q[STAGES-1][0];
    assign mosi_s = sync_q[STAGES-1][1];
    assign ss_n_s = sync_q[STAGES-1][2];

    // ------------------------------------------------------------------------
    // Synchronizer chain and edge-detect register
    // ------------------------------------------------------------------------
    always_ff @(posedge spiClk_internal) begin
        if (!rst_n_i) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= PIN_IDLE;
            end
            sclk_d             <= 1'b0;
            ss_n_d             <= 1'b1;
            line_o.sclk_rise   <= 1'b0;
            line_o.sclk_fall   <= 1'b0;
            line_o.mosi_bit    <= 1'b0;
            line_o.selected    <= 1'b0;
            line_o.frame_start <= 1'b0;
            line_o.frame_end   <= 1'b0;
        end else begin
            // First stage samples the asynchronous pins
            sync_q[0] <= {ss_n_i, mosi_i, sclk_i};
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            sclk_d <= sclk_s;
            ss_n_d <= ss_n_s;
            // Edge pulses, registered so every event lands STAGES + 1 cycles late
            line_o.sclk_rise   <= sclk_s & ~sclk_d;
            line_o.sclk_fall   <= ~sclk_s & sclk_d;
            // MOSI takes the same extra cycle to stay aligned with sclk_rise
            line_o.mosi_bit    <= mosi_s;
            line_o.selected    <= ~ss_n_s;
            line_o.frame_start <= ss_n_d & ~ss_n_s;
            line_o.frame_end   <= ~ss_n_d & ss_n_s;
        end
    end

endmodule

`default_nettype wire

/* design/spi_line_if.sv */
`default_nettype none

// Synchronized pin events, all in the spiClk_internal domain
interface spi_line_if;

    // One-cycle pulses on SCLK edges
    logic sclk_rise;
    logic sclk_fall;

    // MOSI level, delayed to line up with the SCLK pulses
    logic mosi_bit;

    // High while SS_N is low after synchronization
    logic selected;

    // One-cycle pulses on SS_N falling and rising
    logic frame_start;
    logic frame_end;

    // Synchronizer side drives everything
    modport sync_mp (
        output sclk_rise, sclk_fall, mosi_bit, selected, frame_start, frame_end
    );

    // Controller needs the clock and frame events
    modport ctrl_mp (
        input sclk_rise, sclk_fall, selected, frame_start, frame_end
    );

    // Receive shifter only samples the data line
    modport rx_mp (input mosi_bit);

endinterface

`default_nettype wire

/* design/spi_slave_pkg.sv */
`default_nettype none

`include "spi_slave_cfg.svh"

package spi_slave_pkg;

    // One SPI word, used for both the transmit and the receive side
    typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

    // Controller states
    // ST_IDLE  waiting for SS_N to fall
    // ST_SHIFT counting SCLK rises within a word
    // ST_DONE  one cycle after the last bit of a word
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_SHIFT = 2'd1,
        ST_DONE  = 2'd2
    } slave_state_t;

endpackage

`default_nettype wire

/* design/spi_slave_cfg.svh */
`ifndef SPI_SLAVE_CFG_SVH
`define SPI_SLAVE_CFG_SVH

// ---------------------------------------------------------------------------
// SPI slave build constants
// ---------------------------------------------------------------------------

// Bits per SPI word, shifted MSB first
`define SPI_WORD_BITS 8

// Flip-flops in each pin synchronizer chain
`define SPI_SYNC_STAGES 2

`endif
